// File: common/dma_config.svh
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Data and address widths of the system bus.
`define DMA_DATA_W 32
`define DMA_ADDR_W 31

// Device IDs on the system bus and on the register bus.
`define DMA_BUS_DID 4'h3
`define DMA_BUS_SUBDID 4'h1
`define DMA_REG_DID 4'h2

// Each request asks for a fixed burst of beats.
`define DMA_BURST_BEATS 8
`define DMA_FIFO_DEPTH 32

`define DMA_INIT_CREDITS 4
`define DMA_CREDIT_W 3

// Register offsets.
`define DMA_REG_ADDR 24'h000000
`define DMA_REG_LEN 24'h000004
`define DMA_REG_CTRL 24'h000008
`define DMA_REG_STATUS 24'h00000C

`endif

// File: common/dma_pkg.sv
`include "dma_config.svh"

package dma_pkg;

	typedef enum logic {
		BUS_READ  = 1'b0,
		BUS_WRITE = 1'b1
	} bus_mode_t;

	// The drain state waits for beats still in flight after the last request.
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_ISSUE = 2'd1,
		ST_DRAIN = 2'd2
	} ctrl_state_t;

	typedef struct packed {
		logic                   valid;
		bus_mode_t              mode;
		logic [3:0]             did;
		logic [3:0]             subdid;
		logic [`DMA_ADDR_W-1:0] addr;
		logic [3:0]             len;
		logic [`DMA_DATA_W-1:0] data;
	} bus_req_t;

	typedef struct packed {
		logic                   valid;
		logic [3:0]             did;
		logic [3:0]             subdid;
		logic [`DMA_DATA_W-1:0] data;
	} bus_rsp_t;

	typedef struct packed {
		logic                   valid;
		logic                   r_nw;
		logic [3:0]             did;
		logic [23:0]            addr;
		logic [`DMA_DATA_W-1:0] data;
	} reg_req_t;

	// busy_b pulses for one cycle with the reply.
	typedef struct packed {
		logic                   busy_b;
		logic [`DMA_DATA_W-1:0] data;
	} reg_rsp_t;

endpackage

// File: dma_read/dma_reg_if.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_reg_if (
	input  logic                   clk,
	input  logic                   rst_b,
	input  dma_pkg::reg_req_t      reg_req,
	output dma_pkg::reg_rsp_t      reg_rsp,
	input  logic                   busy,
	input  logic [15:0]            remaining,
	output logic                   start,
	output logic [`DMA_ADDR_W-1:0] cfg_addr,
	output logic [15:0]            cfg_len
);

	logic                   access;
	logic                   wr;
	logic [`DMA_DATA_W-1:0] rd_mux;
	logic                   rsp_busy_b_q;
	logic [`DMA_DATA_W-1:0] rsp_data_q;

	assign access = reg_req.valid && (reg_req.did == `DMA_REG_DID);
	assign wr = access && !reg_req.r_nw;

	always_comb begin
		case (reg_req.addr)
			`DMA_REG_ADDR:   rd_mux = {1'b0, cfg_addr};
			`DMA_REG_LEN:    rd_mux = {16'h0000, cfg_len};
			`DMA_REG_STATUS: rd_mux = {busy, 15'h0000, remaining};
			default:         rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			cfg_addr <= '0;
			cfg_len <= '0;
			start <= 1'b0;
			rsp_busy_b_q <= 1'b0;
		end else begin
			if (wr && reg_req.addr == `DMA_REG_ADDR) begin
				cfg_addr <= reg_req.data[`DMA_ADDR_W-1:0];
			end
			if (wr && reg_req.addr == `DMA_REG_LEN) begin
				cfg_len <= reg_req.data[15:0];
			end
			// The controller drops a start that arrives while it is busy.
			start <= wr && (reg_req.addr == `DMA_REG_CTRL) && reg_req.data[0];
			rsp_busy_b_q <= access;
		end
	end

	// Writes reply with zero data.
	always_ff @(posedge clk) begin
		rsp_data_q <= (access && reg_req.r_nw) ? rd_mux : '0;
	end

	assign reg_rsp.busy_b = rsp_busy_b_q;
	assign reg_rsp.data = rsp_data_q;

endmodule

// File: dma_read/dma_read_ctrl.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_read_ctrl (
	input  logic                   clk,
	input  logic                   rst_b,
	input  logic                   start,
	input  logic [`DMA_ADDR_W-1:0] cfg_addr,
	input  logic [15:0]            cfg_len,
	output dma_pkg::bus_req_t      bus_req,
	input  logic                   credit,
	input  logic [5:0]             fifo_count,
	input  logic                   beat_in,
	output logic                   busy,
	output logic [15:0]            remaining
);
	import dma_pkg::*;

	localparam int CREDIT_W = `DMA_CREDIT_W;
	localparam int SPACE_W = 7;
	localparam logic [`DMA_ADDR_W-1:0] ADDR_STEP = `DMA_BURST_BEATS * 4;

	ctrl_state_t            state_q;
	logic [`DMA_ADDR_W-1:0] cur_addr_q;
	logic [15:0]            remaining_q;
	logic [CREDIT_W-1:0]    credits_q;
	logic [5:0]             reserved_q;
	logic [5:0]             reserved_d;
	logic [SPACE_W-1:0]     space_need;
	logic                   issue;
	logic                   req_valid_q;
	logic [`DMA_ADDR_W-1:0] req_addr_q;

	// Beats already in the FIFO plus beats still on their way plus the new burst.
	assign space_need = SPACE_W'(fifo_count) + SPACE_W'(reserved_q) +
		SPACE_W'(`DMA_BURST_BEATS);

	assign issue = (state_q == ST_ISSUE) && (remaining_q != 16'd0) &&
		(credits_q != '0) && (space_need <= SPACE_W'(`DMA_FIFO_DEPTH));

	always_comb begin
		reserved_d = reserved_q;
		if (issue) begin
			reserved_d = reserved_d + 6'(`DMA_BURST_BEATS);
		end
		if (beat_in) begin
			reserved_d = reserved_d - 6'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits_q <= CREDIT_W'(`DMA_INIT_CREDITS);
			reserved_q <= '0;
			req_valid_q <= 1'b0;
		end else begin
			credits_q <= credits_q + CREDIT_W'(credit) - CREDIT_W'(issue);
			reserved_q <= reserved_d;
			req_valid_q <= issue;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state_q <= ST_IDLE;
			remaining_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (start) begin
						remaining_q <= cfg_len;
						state_q <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					if (issue) begin
						remaining_q <= remaining_q - 16'd1;
						if (remaining_q == 16'd1) begin
							state_q <= ST_DRAIN;
						end
					end else if (remaining_q == 16'd0) begin
						state_q <= ST_DRAIN;
					end
				end
				ST_DRAIN: begin
					if (reserved_d == '0) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE && start) begin
			cur_addr_q <= cfg_addr;
		end else if (issue) begin
			cur_addr_q <= cur_addr_q + ADDR_STEP;
		end
		if (issue) begin
			req_addr_q <= cur_addr_q;
		end
	end

	assign bus_req = '{
		valid:  req_valid_q,
		mode:   BUS_READ,
		did:    `DMA_BUS_DID,
		subdid: `DMA_BUS_SUBDID,
		addr:   req_addr_q,
		len:    4'(`DMA_BURST_BEATS),
		data:   '0
	};

	assign busy = (state_q != ST_IDLE);
	assign remaining = remaining_q;

endmodule

// File: logic/read_fifo.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module read_fifo #(
	parameter int DEPTH = 32
) (
	input  logic                   clk,
	input  logic                   rst_b,
	input  dma_pkg::bus_rsp_t      bus_rsp,
	input  logic                   pop,
	output logic [`DMA_DATA_W-1:0] rd_data,
	output logic                   empty,
	output logic [$clog2(DEPTH):0] count,
	output logic                   beat_in
);

	localparam int AW = $clog2(DEPTH);

	logic [`DMA_DATA_W-1:0] mem [DEPTH];
	logic [AW-1:0]          wr_ptr_q;
	logic [AW-1:0]          rd_ptr_q;
	logic [AW:0]            count_q;
	logic                   do_pop;

	assign empty = (count_q == '0);

	// Only beats addressed to this engine are taken.
	assign beat_in = bus_rsp.valid && (bus_rsp.did == `DMA_BUS_DID) &&
		(bus_rsp.subdid == `DMA_BUS_SUBDID);
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (beat_in) begin
			mem[wr_ptr_q] <= bus_rsp.data;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (beat_in) begin
				wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({beat_in, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// The head word shows on rd_data whenever the FIFO holds data.
	assign rd_data = mem[rd_ptr_q];
	assign count = count_q;

endmodule

// File: logic/dma_read_top.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_read_top (
	input  logic                   clk,
	input  logic                   rst_b,
	input  dma_pkg::reg_req_t      reg_req,
	output dma_pkg::reg_rsp_t      reg_rsp,
	output dma_pkg::bus_req_t      bus_req,
	input  logic                   credit,
	input  dma_pkg::bus_rsp_t      bus_rsp,
	input  logic                   pop,
	output logic [`DMA_DATA_W-1:0] rd_data,
	output logic                   empty
);

	logic                   start;
	logic [`DMA_ADDR_W-1:0] cfg_addr;
	logic [15:0]            cfg_len;
	logic                   busy;
	logic [15:0]            remaining;
	logic [5:0]             fifo_count;
	logic                   beat_in;

	dma_reg_if reg_if_i (
		.clk       (clk),
		.rst_b     (rst_b),
		.reg_req   (reg_req),
		.reg_rsp   (reg_rsp),
		.busy      (busy),
		.remaining (remaining),
		.start     (start),
		.cfg_addr  (cfg_addr),
		.cfg_len   (cfg_len)
	);

	dma_read_ctrl ctrl_i (
		.clk        (clk),
		.rst_b      (rst_b),
		.start      (start),
		.cfg_addr   (cfg_addr),
		.cfg_len    (cfg_len),
		.bus_req    (bus_req),
		.credit     (credit),
		.fifo_count (fifo_count),
		.beat_in    (beat_in),
		.busy       (busy),
		.remaining  (remaining)
	);

	read_fifo #(
		.DEPTH (`DMA_FIFO_DEPTH)
	) fifo_i (
		.clk     (clk),
		.rst_b   (rst_b),
		.bus_rsp (bus_rsp),
		.pop     (pop),
		.rd_data (rd_data),
		.empty   (empty),
		.count   (fifo_count),
		.beat_in (beat_in)
	);

endmodule

// File: testbench/dma_read_assert.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_read_assert (
	input logic                     clk,
	input logic                     rst_b,
	input dma_pkg::bus_req_t        bus_req,
	input logic [`DMA_CREDIT_W-1:0] credits,
	input logic [5:0]               fifo_count
);

	localparam int INIT_CREDITS = `DMA_INIT_CREDITS;
	localparam int DEPTH = `DMA_FIFO_DEPTH;

	credit_max: assert property (@(posedge clk) disable iff (!rst_b)
		int'(credits) <= INIT_CREDITS)
		else $error("Credit counter rose above its initial value.");

	// The request shows one cycle after the issue decision.
	req_needs_credit: assert property (@(posedge clk) disable iff (!rst_b)
		bus_req.valid |-> $past(credits) != '0)
		else $error("Request issued with no credit left.");

	fifo_bound: assert property (@(posedge clk) disable iff (!rst_b)
		int'(fifo_count) <= DEPTH)
		else $error("FIFO count exceeds its depth.");

	idle_in_reset: assert property (@(posedge clk)
		!rst_b |-> !bus_req.valid)
		else $error("Request valid during reset.");

endmodule

bind dma_read_top dma_read_assert assert_i (
	.clk        (clk),
	.rst_b      (rst_b),
	.bus_req    (bus_req),
	.credits    (ctrl_i.credits_q),
	.fifo_count (fifo_count)
);

// File: testbench/dma_read_tb.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_read_tb;
	import dma_pkg::*;

	localparam int PERIOD = 40;
	localparam int NUM_ROWS = 5;
	localparam int BEATS = `DMA_BURST_BEATS;

	typedef struct packed {
		logic [31:0] addr;
		logic [15:0] len;
		logic [4:0]  pop_thr;
		logic        foreign;
	} row_t;

	// The consumer pops with a chance of pop_thr out of 16 in each cycle.
	row_t rows [NUM_ROWS] = '{
		'{addr: 32'h0000_1000, len: 16'd2, pop_thr: 5'd16, foreign: 1'b0},
		'{addr: 32'h0000_2000, len: 16'd5, pop_thr: 5'd8, foreign: 1'b1},
		'{addr: 32'h0001_0040, len: 16'd6, pop_thr: 5'd1, foreign: 1'b0},
		'{addr: 32'h0003_0000, len: 16'd3, pop_thr: 5'd4, foreign: 1'b1},
		'{addr: 32'h0000_0800, len: 16'd1, pop_thr: 5'd12, foreign: 1'b1}
	};

	logic        clk = 1'b0;
	logic        rst_b;
	reg_req_t    reg_req;
	reg_rsp_t    reg_rsp;
	bus_req_t    bus_req;
	logic        credit;
	bus_rsp_t    bus_rsp;
	logic        pop;
	logic [31:0] rd_data;
	logic        empty;

	logic [31:0] lfsr_q = 32'ha20c_fc16;
	logic [4:0]  pop_thr = 5'd0;
	logic        foreign = 1'b0;
	logic [30:0] req_q [$];
	int          in_flight = 0;
	logic        burst_active = 1'b0;
	logic [31:0] beat_addr;
	int          beat_idx;
	logic [31:0] exp_word;
	logic [31:0] exp_req;
	int          words_got = 0;
	int          words_exp = 0;

	dma_read_top dut_i (
		.clk     (clk),
		.rst_b   (rst_b),
		.reg_req (reg_req),
		.reg_rsp (reg_rsp),
		.bus_req (bus_req),
		.credit  (credit),
		.bus_rsp (bus_rsp),
		.pop     (pop),
		.rd_data (rd_data),
		.empty   (empty)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Galois form of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	task automatic take_bits(input int n, output logic [3:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[2:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Result: FAILED");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	task automatic reg_access(input logic r_nw, input logic [3:0] did, input logic [23:0] addr,
		input logic [31:0] data, output logic replied, output logic [31:0] rdata);
		@(posedge clk);
		reg_req <= '{valid: 1'b1, r_nw: r_nw, did: did, addr: addr, data: data};
		@(negedge clk);
		check_value(32'(reg_rsp.busy_b), 32'd0, "reply before access sampled");
		@(posedge clk);
		reg_req <= '0;
		@(negedge clk);
		replied = reg_rsp.busy_b;
		rdata = reg_rsp.data;
	endtask

	task automatic reg_write(input logic [23:0] addr, input logic [31:0] data);
		logic        replied;
		logic [31:0] rdata;
		reg_access(1'b0, `DMA_REG_DID, addr, data, replied, rdata);
		check_value(32'(replied), 32'd1, "write reply");
		check_value(rdata, 32'd0, "write reply data");
	endtask

	task automatic reg_read_check(input logic [23:0] addr, input logic [31:0] exp, input string what);
		logic        replied;
		logic [31:0] rdata;
		reg_access(1'b1, `DMA_REG_DID, addr, 32'd0, replied, rdata);
		check_value(32'(replied), 32'd1, "read reply");
		check_value(rdata, exp, what);
	endtask

	// Bus memory model and consumer. All random bits come from this one process.
	always @(posedge clk) begin : drive_model
		logic [3:0] r;
		bus_rsp_t   rsp;
		if (!rst_b) begin
			pop <= 1'b0;
			credit <= 1'b0;
			bus_rsp <= '0;
		end else begin
			take_bits(4, r);
			pop <= ({1'b0, r} < pop_thr);
			take_bits(2, r);
			if (in_flight > 0 && r[1:0] == 2'b11) begin
				credit <= 1'b1;
				in_flight = in_flight - 1;
			end else begin
				credit <= 1'b0;
			end
			rsp = '0;
			if (!burst_active && req_q.size() > 0) begin
				beat_addr = {1'b0, req_q.pop_front()};
				beat_idx = 0;
				burst_active = 1'b1;
			end
			take_bits(2, r);
			if (burst_active && r[1:0] != 2'b00) begin
				rsp = '{valid: 1'b1, did: `DMA_BUS_DID, subdid: `DMA_BUS_SUBDID,
					data: beat_addr + 32'(4 * beat_idx)};
				beat_idx = beat_idx + 1;
				if (beat_idx == BEATS) begin
					burst_active = 1'b0;
				end
			end else if (foreign && r[1:0] == 2'b00) begin
				take_bits(1, r);
				// Odd data can never match a word address.
				rsp.valid = 1'b1;
				rsp.did = r[0] ? `DMA_BUS_DID : 4'hc;
				rsp.subdid = r[0] ? 4'h6 : `DMA_BUS_SUBDID;
				rsp.data = 32'hfeed_0003;
			end
			bus_rsp <= rsp;
		end
	end

	always @(negedge clk) begin
		if (rst_b) begin
			if (bus_req.valid) begin
				check_value(32'(bus_req.mode), 32'(BUS_READ), "request mode");
				check_value(32'(bus_req.did), 32'(`DMA_BUS_DID), "request did");
				check_value(32'(bus_req.subdid), 32'(`DMA_BUS_SUBDID), "request subdid");
				check_value(32'(bus_req.len), 32'(BEATS), "request length");
				check_value(bus_req.data, 32'd0, "request data");
				check_value({1'b0, bus_req.addr}, exp_req, "request address");
				exp_req = exp_req + 32'(BEATS * 4);
				req_q.push_back(bus_req.addr);
				in_flight = in_flight + 1;
				check_value(32'(in_flight <= `DMA_INIT_CREDITS), 32'd1,
					"requests without credit within limit");
			end
			if (pop && !empty) begin
				check_value(32'(words_got < words_exp), 32'd1, "pop within transfer length");
				check_value(rd_data, exp_word, "popped word");
				exp_word = exp_word + 32'd4;
				words_got = words_got + 1;
			end
		end
	end

	initial begin
		int total_beats;
		int limit;
		total_beats = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			total_beats = total_beats + int'(rows[i].len) * BEATS;
		end
		// Slowest consumer pops once in 16 cycles, so 64 cycles per beat is ample.
		limit = total_beats * 64 + NUM_ROWS * 64 + 200;
		repeat (limit) @(posedge clk);
		$display("Timeout: the transfers did not finish within %0d cycles.", limit);
		$display("Result: FAILED");
		$fatal(1, "Watchdog expired.");
	end

	initial begin
		logic        replied;
		logic [31:0] rdata;
		rst_b = 1'b0;
		reg_req = '0;
		credit = 1'b0;
		bus_rsp = '0;
		pop = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_value(32'(bus_req.valid), 32'd0, "request valid in reset");
		check_value(32'(reg_rsp.busy_b), 32'd0, "reply in reset");
		check_value(32'(empty), 32'd1, "empty in reset");
		@(posedge clk);
		rst_b <= 1'b1;

		reg_write(`DMA_REG_ADDR, 32'h0012_3450);
		reg_read_check(`DMA_REG_ADDR, 32'h0012_3450, "address readback");
		reg_write(`DMA_REG_LEN, 32'h0000_00a5);
		reg_read_check(`DMA_REG_LEN, 32'h0000_00a5, "length readback");
		// Accesses for another device must stay silent and change nothing.
		reg_access(1'b0, 4'h5, `DMA_REG_ADDR, 32'h0000_0ff0, replied, rdata);
		check_value(32'(replied), 32'd0, "reply to foreign write");
		reg_access(1'b1, 4'h5, `DMA_REG_ADDR, 32'd0, replied, rdata);
		check_value(32'(replied), 32'd0, "reply to foreign read");
		reg_read_check(`DMA_REG_ADDR, 32'h0012_3450, "address after foreign write");
		reg_read_check(`DMA_REG_STATUS, 32'd0, "idle status");

		for (int i = 0; i < NUM_ROWS; i++) begin
			pop_thr = rows[i].pop_thr;
			foreign = rows[i].foreign;
			exp_word = rows[i].addr;
			exp_req = rows[i].addr;
			words_got = 0;
			words_exp = int'(rows[i].len) * BEATS;
			reg_write(`DMA_REG_ADDR, rows[i].addr);
			reg_write(`DMA_REG_LEN, 32'(rows[i].len));
			reg_write(`DMA_REG_CTRL, 32'd1);
			reg_access(1'b1, `DMA_REG_DID, `DMA_REG_STATUS, 32'd0, replied, rdata);
			check_value(32'(replied), 32'd1, "status reply");
			check_value(32'(rdata[31]), 32'd1, "busy after start");
			// A new address and a second start during the transfer leave it alone.
			reg_write(`DMA_REG_ADDR, 32'h0040_0000);
			reg_write(`DMA_REG_CTRL, 32'd1);
			while (words_got < words_exp) begin
				@(negedge clk);
			end
			pop_thr = 5'd16;
			reg_read_check(`DMA_REG_STATUS, 32'd0, "status after transfer");
			repeat (4) begin
				@(negedge clk);
				check_value(32'(empty), 32'd1, "empty after transfer");
			end
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+common
common/dma_pkg.sv
dma_read/dma_reg_if.sv
dma_read/dma_read_ctrl.sv
logic/read_fifo.sv
logic/dma_read_top.sv
testbench/dma_read_assert.sv
testbench/dma_read_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module dma_read_tb \
	-o dma_read_sim && ./obj_dir/dma_read_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
